// File: verilog/pmu_pkg.sv
package pmu_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    // Register and counter width
    localparam int REG_WIDTH = 32;
    // Counter bank size
    localparam int N_COUNTERS = 8;
    // Counter index bits
    localparam int CNT_IDX_WIDTH = $clog2(N_COUNTERS);
    // Register address bits
    localparam int ADDR_WIDTH = 4;
    // Quota sum, three carry bits for eight terms
    localparam int SUM_WIDTH = REG_WIDTH + 3;

    typedef logic [REG_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [N_COUNTERS-1:0] event_vec_t;
    typedef logic [N_COUNTERS-1:0][REG_WIDTH-1:0] count_array_t;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam reg_addr_t ADDR_CFG = 4'd0;
    // Counters at 1 to 8
    localparam reg_addr_t ADDR_CNT_BASE = 4'd1;
    localparam reg_addr_t ADDR_OVF_MASK = 4'd9;
    // Read only
    localparam reg_addr_t ADDR_OVF_VECT = 4'd10;
    localparam reg_addr_t ADDR_QUOTA_MASK = 4'd11;
    localparam reg_addr_t ADDR_QUOTA_LIMIT = 4'd12;

    // Bit positions in the configuration word
    localparam int CFG_BIT_CNT_EN = 0;
    localparam int CFG_BIT_CNT_SOFTRST = 1;
    localparam int CFG_BIT_OVF_EN = 2;
    localparam int CFG_BIT_OVF_SOFTRST = 3;
    localparam int CFG_BIT_QUOTA_SOFTRST = 4;
    localparam int CFG_SELFTEST_LSB = 30;

    // Self-test event source
    typedef enum logic [1:0] {
        SELFTEST_OFF     = 2'b00,
        SELFTEST_ALL_ON  = 2'b01,
        SELFTEST_ALL_OFF = 2'b10,
        SELFTEST_ONE_ON  = 2'b11
    } selftest_mode_e;

    // Decoded configuration word
    typedef struct packed {
        selftest_mode_e selftest;
        logic           quota_softrst;
        logic           ovf_softrst;
        logic           ovf_en;
        logic           cnt_softrst;
        logic           cnt_en;
    } pmu_cfg_t;

    // Counter preload request
    typedef struct packed {
        logic                     valid;
        logic [CNT_IDX_WIDTH-1:0] index;
        word_t                    value;
    } cnt_write_t;

endpackage

// File: verilog/pmu_regs.sv
`timescale 1ns/100ps

module pmu_regs (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  wr_en_i,
    input  pmu_pkg::reg_addr_t    addr_i,
    input  pmu_pkg::word_t        wdata_i,
    output pmu_pkg::word_t        rdata_o,
    input  pmu_pkg::count_array_t counts_i,
    input  pmu_pkg::event_vec_t   ovf_vect_i,
    output pmu_pkg::pmu_cfg_t     cfg_o,
    output pmu_pkg::cnt_write_t   cnt_write_o,
    output pmu_pkg::event_vec_t   ovf_mask_o,
    output pmu_pkg::event_vec_t   quota_mask_o,
    output pmu_pkg::word_t        quota_limit_o
);
    import pmu_pkg::*;

    pmu_cfg_t   cfg_q;
    event_vec_t ovf_mask_q;
    event_vec_t quota_mask_q;
    word_t      quota_limit_q;

    // Counter window decode
    logic       cnt_hit;
    reg_addr_t  cnt_offset;

    assign cnt_hit = (addr_i >= ADDR_CNT_BASE) &&
                     (addr_i < ADDR_CNT_BASE + reg_addr_t'(N_COUNTERS));
    assign cnt_offset = addr_i - ADDR_CNT_BASE;

    // ----------------------------------------
    // Writable registers
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cfg_q         <= '0;
            ovf_mask_q    <= '0;
            quota_mask_q  <= '0;
            quota_limit_q <= '0;
        end else if (wr_en_i) begin
            case (addr_i)
                ADDR_CFG: begin
                    cfg_q.cnt_en        <= wdata_i[CFG_BIT_CNT_EN];
                    cfg_q.cnt_softrst   <= wdata_i[CFG_BIT_CNT_SOFTRST];
                    cfg_q.ovf_en        <= wdata_i[CFG_BIT_OVF_EN];
                    cfg_q.ovf_softrst   <= wdata_i[CFG_BIT_OVF_SOFTRST];
                    cfg_q.quota_softrst <= wdata_i[CFG_BIT_QUOTA_SOFTRST];
                    cfg_q.selftest      <= selftest_mode_e'(wdata_i[CFG_SELFTEST_LSB +: 2]);
                end
                ADDR_OVF_MASK:    ovf_mask_q    <= wdata_i[N_COUNTERS-1:0];
                ADDR_QUOTA_MASK:  quota_mask_q  <= wdata_i[N_COUNTERS-1:0];
                ADDR_QUOTA_LIMIT: quota_limit_q <= wdata_i;
                // Counters, vector and holes land here
                default: ;
            endcase
        end
    end

    // Preload request lives only during the strobe cycle
    assign cnt_write_o.valid = wr_en_i && cnt_hit;
    assign cnt_write_o.index = cnt_offset[CNT_IDX_WIDTH-1:0];
    assign cnt_write_o.value = wdata_i;

    assign cfg_o         = cfg_q;
    assign ovf_mask_o    = ovf_mask_q;
    assign quota_mask_o  = quota_mask_q;
    assign quota_limit_o = quota_limit_q;

    // ----------------------------------------
    // Read multiplexer
    // ----------------------------------------
    always_comb begin
        rdata_o = '0;
        if (cnt_hit) begin
            rdata_o = counts_i[cnt_offset[CNT_IDX_WIDTH-1:0]];
        end else begin
            case (addr_i)
                ADDR_CFG: begin
                    // Spare bits read zero
                    rdata_o[CFG_BIT_CNT_EN]        = cfg_q.cnt_en;
                    rdata_o[CFG_BIT_CNT_SOFTRST]   = cfg_q.cnt_softrst;
                    rdata_o[CFG_BIT_OVF_EN]        = cfg_q.ovf_en;
                    rdata_o[CFG_BIT_OVF_SOFTRST]   = cfg_q.ovf_softrst;
                    rdata_o[CFG_BIT_QUOTA_SOFTRST] = cfg_q.quota_softrst;
                    rdata_o[CFG_SELFTEST_LSB +: 2] = cfg_q.selftest;
                end
                ADDR_OVF_MASK:    rdata_o = word_t'(ovf_mask_q);
                ADDR_OVF_VECT:    rdata_o = word_t'(ovf_vect_i);
                ADDR_QUOTA_MASK:  rdata_o = word_t'(quota_mask_q);
                ADDR_QUOTA_LIMIT: rdata_o = quota_limit_q;
                default:          rdata_o = '0;
            endcase
        end
    end

    // Strobed write into the counter window lands in that counter
    a_preload_on_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (wr_en_i && cnt_hit && !cfg_q.cnt_softrst) |=>
            (counts_i[$past(cnt_offset[CNT_IDX_WIDTH-1:0])] == $past(wdata_i)));

endmodule

// File: verilog/pmu_counters.sv
`timescale 1ns/100ps

module pmu_counters (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  pmu_pkg::pmu_cfg_t     cfg_i,
    input  pmu_pkg::cnt_write_t   cnt_write_i,
    input  pmu_pkg::event_vec_t   events_i,
    output pmu_pkg::count_array_t counts_o,
    output pmu_pkg::event_vec_t   wrap_o
);
    import pmu_pkg::*;

    event_vec_t   events_sel;
    event_vec_t   load_sel;
    event_vec_t   inc_sel;
    count_array_t counts_q;
    event_vec_t   wrap_q;

    // ----------------------------------------
    // Event source
    // ----------------------------------------
    always_comb begin
        case (cfg_i.selftest)
            SELFTEST_OFF:     events_sel = events_i;
            SELFTEST_ALL_ON:  events_sel = '1;
            SELFTEST_ALL_OFF: events_sel = '0;
            // Only counter 0 ticks
            SELFTEST_ONE_ON:  events_sel = event_vec_t'(1);
            default:          events_sel = events_i;
        endcase
    end

    // One-hot preload target
    assign load_sel = cnt_write_i.valid ? (event_vec_t'(1) << cnt_write_i.index) : '0;
    assign inc_sel  = events_sel & {N_COUNTERS{cfg_i.cnt_en}};

    // ----------------------------------------
    // Counter bank
    // ----------------------------------------
    // Priority: soft reset, preload, increment
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            counts_q <= '0;
            wrap_q   <= '0;
        end else begin
            for (int i = 0; i < N_COUNTERS; i++) begin
                wrap_q[i] <= 1'b0;
                if (cfg_i.cnt_softrst) begin
                    counts_q[i] <= '0;
                end else if (load_sel[i]) begin
                    counts_q[i] <= cnt_write_i.value;
                end else if (inc_sel[i]) begin
                    counts_q[i] <= counts_q[i] + word_t'(1);
                    // All ones rolls over to zero
                    wrap_q[i]   <= &counts_q[i];
                end
            end
        end
    end

    assign counts_o = counts_q;
    assign wrap_o   = wrap_q;

    // Whole bank reads zero after a soft reset edge
    a_softrst_clears: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cfg_i.cnt_softrst |=> (counts_o == '0 && wrap_o == '0));

endmodule

// File: verilog/pmu_overflow.sv
`timescale 1ns/100ps

module pmu_overflow (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pmu_pkg::pmu_cfg_t   cfg_i,
    input  pmu_pkg::event_vec_t wrap_i,
    input  pmu_pkg::event_vec_t ovf_mask_i,
    output pmu_pkg::event_vec_t ovf_vect_o,
    output logic                intr_overflow_o
);
    import pmu_pkg::*;

    event_vec_t ovf_vect_q;

    // ----------------------------------------
    // Sticky overflow bits
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ovf_vect_q <= '0;
        end else if (cfg_i.ovf_softrst) begin
            ovf_vect_q <= '0;
        end else if (cfg_i.ovf_en) begin
            // Accumulate new rollovers
            ovf_vect_q <= ovf_vect_q | wrap_i;
        end
    end

    assign ovf_vect_o = ovf_vect_q;

    // Mask applies combinationally
    assign intr_overflow_o = |(ovf_vect_q & ovf_mask_i);

    // Bits only fall through the soft reset
    a_vect_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !cfg_i.ovf_softrst |=> (($past(ovf_vect_q) & ~ovf_vect_q) == '0));

endmodule

// File: verilog/pmu_quota.sv
`timescale 1ns/100ps

module pmu_quota (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  pmu_pkg::pmu_cfg_t     cfg_i,
    input  pmu_pkg::count_array_t counts_i,
    input  pmu_pkg::event_vec_t   quota_mask_i,
    input  pmu_pkg::word_t        quota_limit_i,
    output logic                  intr_quota_o
);
    import pmu_pkg::*;

    logic [SUM_WIDTH-1:0] sum_d;
    logic [SUM_WIDTH-1:0] sum_q;
    logic                 quota_hit_q;

    // Masked sum of the whole bank
    always_comb begin
        sum_d = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            if (quota_mask_i[i]) begin
                sum_d = sum_d + SUM_WIDTH'(counts_i[i]);
            end
        end
    end

    // ----------------------------------------
    // Stage 1 sum, stage 2 compare
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sum_q       <= '0;
            quota_hit_q <= 1'b0;
        end else if (cfg_i.quota_softrst) begin
            // Flush both stages
            sum_q       <= '0;
            quota_hit_q <= 1'b0;
        end else begin
            sum_q       <= sum_d;
            quota_hit_q <= quota_hit_q | (sum_q > SUM_WIDTH'(quota_limit_i));
        end
    end

    assign intr_quota_o = quota_hit_q;

    // Interrupt held until soft reset
    a_quota_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (intr_quota_o && !cfg_i.quota_softrst) |=> intr_quota_o);

endmodule

// File: verilog/pmu_top.sv
`timescale 1ns/100ps

module pmu_top (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                wr_en_i,
    input  pmu_pkg::reg_addr_t  addr_i,
    input  pmu_pkg::word_t      wdata_i,
    output pmu_pkg::word_t      rdata_o,
    input  pmu_pkg::event_vec_t events_i,
    output logic                intr_overflow_o,
    output logic                intr_quota_o
);
    import pmu_pkg::*;

    // ----------------------------------------
    // Inter-block wires
    // ----------------------------------------
    pmu_cfg_t     cfg;
    cnt_write_t   cnt_write;
    event_vec_t   ovf_mask;
    event_vec_t   quota_mask;
    word_t        quota_limit;
    count_array_t counts;
    event_vec_t   wrap;
    event_vec_t   ovf_vect;

    // Register file and read path
    pmu_regs pmu_regs_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .wr_en_i       (wr_en_i),
        .addr_i        (addr_i),
        .wdata_i       (wdata_i),
        .rdata_o       (rdata_o),
        .counts_i      (counts),
        .ovf_vect_i    (ovf_vect),
        .cfg_o         (cfg),
        .cnt_write_o   (cnt_write),
        .ovf_mask_o    (ovf_mask),
        .quota_mask_o  (quota_mask),
        .quota_limit_o (quota_limit)
    );

    // Event counters with self-test source
    pmu_counters pmu_counters_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cfg_i       (cfg),
        .cnt_write_i (cnt_write),
        .events_i    (events_i),
        .counts_o    (counts),
        .wrap_o      (wrap)
    );

    // Overflow vector and interrupt
    pmu_overflow pmu_overflow_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .cfg_i           (cfg),
        .wrap_i          (wrap),
        .ovf_mask_i      (ovf_mask),
        .ovf_vect_o      (ovf_vect),
        .intr_overflow_o (intr_overflow_o)
    );

    // Quota interrupt
    pmu_quota pmu_quota_i (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .cfg_i         (cfg),
        .counts_i      (counts),
        .quota_mask_i  (quota_mask),
        .quota_limit_i (quota_limit),
        .intr_quota_o  (intr_quota_o)
    );

endmodule

// File: tests/pmu_tb.sv
`timescale 1ns/100ps

module pmu_tb;
    import pmu_pkg::*;

    // ----------------------------------------
    // Run length
    // ----------------------------------------
    localparam int RESET_CYCLES = 3;
    localparam int PH1_CYCLES = 200;
    localparam int PH2_CYCLES = 310;
    localparam int PH3_CYCLES = 185;
    localparam int PH4_CYCLES = 80;
    localparam int PH5_CYCLES = 165;
    localparam int PH6_CYCLES = 2000;
    localparam int TOTAL_CYCLES = RESET_CYCLES + PH1_CYCLES + PH2_CYCLES + PH3_CYCLES +
                                  PH4_CYCLES + PH5_CYCLES + PH6_CYCLES;
    // Margin of one half over the planned length
    localparam int TIMEOUT_CYCLES = (TOTAL_CYCLES * 3) / 2;

    logic       clk_i;
    logic       rst_n_i;
    logic       wr_en_i;
    reg_addr_t  addr_i;
    word_t      wdata_i;
    word_t      rdata_o;
    event_vec_t events_i;
    logic       intr_overflow_o;
    logic       intr_quota_o;

    // Reference model state
    pmu_cfg_t             m_cfg;
    event_vec_t           m_ovf_mask;
    event_vec_t           m_quota_mask;
    word_t                m_limit;
    word_t                m_cnt [N_COUNTERS];
    event_vec_t           m_wrap;
    event_vec_t           m_vect;
    logic [SUM_WIDTH-1:0] m_sum;
    logic                 m_hit;

    logic [31:0] lfsr_state;
    int          check_count;
    int          error_count;
    int          cycle_count;

    pmu_top pmu_top_i (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .wr_en_i         (wr_en_i),
        .addr_i          (addr_i),
        .wdata_i         (wdata_i),
        .rdata_o         (rdata_o),
        .events_i        (events_i),
        .intr_overflow_o (intr_overflow_o),
        .intr_quota_o    (intr_quota_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Galois LFSR, one shift per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] result;
        logic        lsb;
        result = '0;
        for (int k = 0; k < n; k++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            result = {result[30:0], lsb};
        end
        return result;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    task automatic model_reset();
        m_cfg = '0;
        m_ovf_mask = '0;
        m_quota_mask = '0;
        m_limit = '0;
        m_wrap = '0;
        m_vect = '0;
        m_sum = '0;
        m_hit = 1'b0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            m_cnt[i] = '0;
        end
    endtask

    // Expected read data per register map
    function automatic word_t model_read(input reg_addr_t addr);
        word_t value;
        value = '0;
        if (addr >= 4'd1 && addr <= 4'd8) begin
            value = m_cnt[addr - 4'd1];
        end else begin
            case (addr)
                4'd0: begin
                    value[0] = m_cfg.cnt_en;
                    value[1] = m_cfg.cnt_softrst;
                    value[2] = m_cfg.ovf_en;
                    value[3] = m_cfg.ovf_softrst;
                    value[4] = m_cfg.quota_softrst;
                    value[31:30] = m_cfg.selftest;
                end
                4'd9:  value = {24'd0, m_ovf_mask};
                4'd10: value = {24'd0, m_vect};
                4'd11: value = {24'd0, m_quota_mask};
                4'd12: value = m_limit;
                default: value = '0;
            endcase
        end
        return value;
    endfunction

    // Rising edge update, all blocks see the old state
    task automatic model_update(input logic we, input reg_addr_t addr, input word_t wdata,
                                input event_vec_t ev);
        word_t                next_cnt [N_COUNTERS];
        event_vec_t           next_wrap;
        event_vec_t           sel;
        logic [SUM_WIDTH-1:0] next_sum;
        // Self-test event source
        case (m_cfg.selftest)
            SELFTEST_ALL_ON:  sel = 8'hFF;
            SELFTEST_ALL_OFF: sel = 8'h00;
            SELFTEST_ONE_ON:  sel = 8'h01;
            default:          sel = ev;
        endcase
        next_sum = '0;
        for (int i = 0; i < N_COUNTERS; i++) begin
            next_wrap[i] = 1'b0;
            next_cnt[i] = m_cnt[i];
            if (m_cfg.cnt_softrst) begin
                next_cnt[i] = '0;
            end else if (we && addr == reg_addr_t'(i + 1)) begin
                next_cnt[i] = wdata;
            end else if (m_cfg.cnt_en && sel[i]) begin
                next_wrap[i] = (m_cnt[i] == 32'hFFFF_FFFF);
                next_cnt[i] = m_cnt[i] + 32'd1;
            end
            if (m_quota_mask[i]) begin
                next_sum = next_sum + {3'b000, m_cnt[i]};
            end
        end
        // Quota pipeline
        if (m_cfg.quota_softrst) begin
            m_sum = '0;
            m_hit = 1'b0;
        end else begin
            m_hit = m_hit | (m_sum > {3'b000, m_limit});
            m_sum = next_sum;
        end
        // Sticky overflow vector
        if (m_cfg.ovf_softrst) begin
            m_vect = '0;
        end else if (m_cfg.ovf_en) begin
            m_vect = m_vect | m_wrap;
        end
        // Register writes last
        if (we) begin
            case (addr)
                4'd0: begin
                    m_cfg.cnt_en = wdata[0];
                    m_cfg.cnt_softrst = wdata[1];
                    m_cfg.ovf_en = wdata[2];
                    m_cfg.ovf_softrst = wdata[3];
                    m_cfg.quota_softrst = wdata[4];
                    m_cfg.selftest = selftest_mode_e'(wdata[31:30]);
                end
                4'd9:  m_ovf_mask = wdata[7:0];
                4'd11: m_quota_mask = wdata[7:0];
                4'd12: m_limit = wdata;
                default: ;
            endcase
        end
        for (int i = 0; i < N_COUNTERS; i++) begin
            m_cnt[i] = next_cnt[i];
        end
        m_wrap = next_wrap;
    endtask

    // ----------------------------------------
    // One bus cycle with checks
    // ----------------------------------------
    task automatic step(input logic we, input reg_addr_t addr, input word_t wdata,
                        input event_vec_t ev);
        @(negedge clk_i);
        wr_en_i = we;
        addr_i = addr;
        wdata_i = wdata;
        events_i = ev;
        // Settle the read path before sampling
        #20;
        check_value("rdata_o", rdata_o, model_read(addr));
        check_value("intr_overflow_o", intr_overflow_o, |(m_vect & m_ovf_mask));
        check_value("intr_quota_o", intr_quota_o, m_hit);
        @(posedge clk_i);
        model_update(we, addr, wdata, ev);
    endtask

    // All soft resets for one cycle, then config cleared
    task automatic clear_all();
        step(1'b1, ADDR_CFG, 32'h0000_001A, '0);
        step(1'b1, ADDR_CFG, 32'h0000_0000, '0);
    endtask

    task automatic read_random_counter(input event_vec_t ev);
        step(1'b0, reg_addr_t'(1 + random_bits(3)), '0, ev);
    endtask

    // Counters just below rollover
    task automatic preload_near_top();
        for (int i = 0; i < N_COUNTERS; i++) begin
            step(1'b1, reg_addr_t'(i + 1), 32'hFFFF_FFF0 | random_bits(4), '0);
        end
    endtask

    // ----------------------------------------
    // Timeout
    // ----------------------------------------
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_i);
            cycle_count++;
        end
        $display("Run timed out after %0d cycles before the tests finished",
                 cycle_count);
        $display("Checks: %0d, mismatches: %0d", check_count, error_count);
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        reg_addr_t addr;
        word_t     data;
        logic [2:0] action;
        lfsr_state = 32'h87bc;
        check_count = 0;
        error_count = 0;
        rst_n_i = 1'b0;
        wr_en_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        events_i = '0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        // Random writes, each read back next cycle
        for (int j = 0; j < PH1_CYCLES / 2; j++) begin
            addr = reg_addr_t'(random_bits(4));
            step(1'b1, addr, random_bits(32), '0);
            step(1'b0, addr, '0, '0);
        end

        // Counting with random events, freeze, soft reset
        clear_all();
        step(1'b1, ADDR_CFG, 32'h0000_0001, '0);
        for (int j = 0; j < 250; j++) begin
            read_random_counter(event_vec_t'(random_bits(8)));
        end
        step(1'b1, ADDR_CFG, 32'h0000_0000, '0);
        for (int j = 0; j < 50; j++) begin
            read_random_counter(event_vec_t'(random_bits(8)));
        end
        step(1'b1, ADDR_CFG, 32'h0000_0002, '0);
        step(1'b1, ADDR_CFG, 32'h0000_0000, '0);
        for (int j = 0; j < N_COUNTERS; j++) begin
            step(1'b0, reg_addr_t'(j + 1), '0, event_vec_t'(random_bits(8)));
        end

        // Self-test modes ALL_ON, ALL_OFF, ONE_ON
        clear_all();
        for (int mode = 1; mode < 4; mode++) begin
            step(1'b1, ADDR_CFG, {mode[1:0], 30'h0000_0001}, '0);
            for (int j = 0; j < 60; j++) begin
                read_random_counter(event_vec_t'(random_bits(8)));
            end
        end

        // Wrap with ovf_en off, then on
        clear_all();
        preload_near_top();
        step(1'b1, ADDR_CFG, 32'h4000_0001, '0);
        for (int j = 0; j < 24; j++) begin
            step(1'b0, ADDR_OVF_VECT, '0, '0);
        end
        step(1'b1, ADDR_CFG, 32'h0000_0000, '0);
        preload_near_top();
        step(1'b1, ADDR_OVF_MASK, random_bits(8), '0);
        step(1'b1, ADDR_CFG, 32'h4000_0005, '0);
        for (int j = 0; j < 24; j++) begin
            if (j % 6 == 5) begin
                step(1'b1, ADDR_OVF_MASK, random_bits(8), '0);
            end else begin
                step(1'b0, ADDR_OVF_VECT, '0, '0);
            end
        end
        step(1'b1, ADDR_CFG, 32'h0000_0008, '0);
        step(1'b1, ADDR_CFG, 32'h0000_0000, '0);
        for (int j = 0; j < 4; j++) begin
            step(1'b0, ADDR_OVF_VECT, '0, '0);
        end

        // Quota with small limit
        clear_all();
        step(1'b1, ADDR_QUOTA_MASK, random_bits(8) | 32'h1, '0);
        step(1'b1, ADDR_QUOTA_LIMIT, random_bits(6) + 32'd8, '0);
        step(1'b1, ADDR_CFG, 32'h0000_0001, '0);
        for (int j = 0; j < 150; j++) begin
            read_random_counter(event_vec_t'(random_bits(8)));
        end
        step(1'b1, ADDR_CFG, 32'h0000_0011, '0);
        step(1'b1, ADDR_CFG, 32'h0000_0000, '0);
        for (int j = 0; j < 4; j++) begin
            read_random_counter('0);
        end

        // Random mix of writes, reads and soft resets
        clear_all();
        for (int j = 0; j < PH6_CYCLES; j++) begin
            action = 3'(random_bits(3));
            addr = reg_addr_t'(random_bits(4));
            data = random_bits(32);
            // Soft resets in about one config write of eight
            if (addr == ADDR_CFG && random_bits(3) != 3'd0) begin
                data[4:1] = 4'b0000;
            end
            // Some preloads close to rollover
            if (addr >= 4'd1 && addr <= 4'd8 && random_bits(1) == 1'b1) begin
                data = 32'hFFFF_FF00 | data[7:0];
            end
            step(action < 3'd2, addr, data, event_vec_t'(random_bits(8)));
        end

        $display("Checks: %0d, mismatches: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

// File: list.f
verilog/pmu_pkg.sv
verilog/pmu_regs.sv
verilog/pmu_counters.sv
verilog/pmu_overflow.sv
verilog/pmu_quota.sv
verilog/pmu_top.sv
tests/pmu_tb.sv

// File: Bender.yml
package:
  name: pmu

sources:
  - verilog/pmu_pkg.sv
  - verilog/pmu_regs.sv
  - verilog/pmu_counters.sv
  - verilog/pmu_overflow.sv
  - verilog/pmu_quota.sv
  - verilog/pmu_top.sv
  - target: test
    files:
      - tests/pmu_tb.sv
